// File: source/spmm_pkg.sv
package spmm_pkg;

  // matrix sizes
  localparam int DATA_WIDTH       = 8;
  localparam int DOT_PRODUCT_SIZE = 5;
  localparam int W_NUM_OF_COLS    = 5;

  // sparse row fields
  localparam int COL_IDX_WIDTH    = 3;
  localparam int ROW_LEN_WIDTH    = 3;

  // flow control
  localparam int FIFO_DEPTH       = 4;
  localparam int OUT_CREDITS      = 2;

  // derived counter widths
  localparam int FIFO_PTR_WIDTH   = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH   = $clog2(FIFO_DEPTH + 1);
  localparam int CREDIT_WIDTH     = $clog2(OUT_CREDITS + 1);

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [COL_IDX_WIDTH-1:0]  col_idx_t;
  typedef logic [ROW_LEN_WIDTH-1:0]  row_len_t;
  typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;
  typedef logic [CREDIT_WIDTH-1:0]   credit_t;

  // one compressed row of H, entries at positions below row_len are valid
  typedef struct packed {
    col_idx_t [DOT_PRODUCT_SIZE-1:0] col_idx;
    data_t    [DOT_PRODUCT_SIZE-1:0] value;
    row_len_t                        row_len;
    logic                            last;
  } hrow_t;

  // W row on the write side, W column per lane
  // W is square here so both uses have five elements
  typedef data_t [DOT_PRODUCT_SIZE-1:0] wrow_t;

  // one dense result row
  typedef struct packed {
    data_t [W_NUM_OF_COLS-1:0] data;
    logic                      last;
  } out_row_t;

  // row controller states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    HOLD
  } spmm_state_t;

endpackage

// File: source/row_fifo.sv
module row_fifo (
  input  logic            clk,
  input  logic            rst_n_i,
  // write side, guarded by sender credits
  input  logic            push_i,
  input  spmm_pkg::hrow_t push_row_i,
  // read side
  input  logic            pop_i,
  output logic            head_valid_o,
  output spmm_pkg::hrow_t head_row_o,
  // one credit back per freed slot
  output logic            credit_o
);
  import spmm_pkg::*;

  hrow_t     mem_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      do_pop;

  assign head_valid_o = (count_q != '0);
  assign head_row_o   = mem_q[rd_ptr_q];
  assign do_pop       = pop_i && head_valid_o;

  // slot freed in the pop cycle
  assign credit_o     = do_pop;

  // row storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_row_i;
    end
  end

  // pointers wrap naturally at FIFO_DEPTH
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/weight_store.sv
module weight_store (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  // row write port
  input  logic                                          we_i,
  input  spmm_pkg::col_idx_t                            row_i,
  input  spmm_pkg::wrow_t                               data_i,
  // transposed read, one W column per lane
  output spmm_pkg::wrow_t [spmm_pkg::W_NUM_OF_COLS-1:0] cols_o
);
  import spmm_pkg::*;

  // W kept row major, one wrow_t per shared-dimension index
  wrow_t [DOT_PRODUCT_SIZE-1:0] w_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_q <= '0;
    end else if (we_i && (row_i < col_idx_t'(DOT_PRODUCT_SIZE))) begin
      w_q[row_i] <= data_i;
    end
  end

  // transpose, lane c sees W[k][c] for every k
  for (genvar c = 0; c < W_NUM_OF_COLS; c++) begin : g_col
    for (genvar k = 0; k < DOT_PRODUCT_SIZE; k++) begin : g_row
      assign cols_o[c][k] = w_q[k][c];
    end
  end

endmodule

// File: source/spv.sv
module spv (
  input  logic            clk,
  input  logic            rst_n_i,
  // row and weight column
  input  logic            start_i,
  input  spmm_pkg::hrow_t row_i,
  input  spmm_pkg::wrow_t wcol_i,
  // result
  output logic            done_o,
  output spmm_pkg::data_t result_o
);
  import spmm_pkg::*;

  hrow_t    row_q;
  row_len_t idx_q;
  row_len_t idx_next;
  data_t    acc_q;
  logic     busy_q;
  logic     done_q;
  data_t    entry_val;
  data_t    entry_w;
  data_t    prod;

  // current entry and its gathered weight
  assign entry_val = row_q.value[idx_q];
  assign entry_w   = wcol_i[row_q.col_idx[idx_q]];

  // product kept at 8 bits, sum wraps modulo 256
  assign prod      = entry_val * entry_w;
  assign idx_next  = idx_q + 1'b1;

  assign done_o    = done_q;
  assign result_o  = acc_q;

  // latched row and running sum
  always_ff @(posedge clk) begin
    if (start_i) begin
      row_q <= row_i;
      acc_q <= '0;
    end else if (busy_q) begin
      acc_q <= acc_q + prod;
    end
  end

  // entry counter and done pulse
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        idx_q <= '0;
        // empty row finishes right away with a zero sum
        if (row_i.row_len == '0) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
        end
      end else if (busy_q) begin
        idx_q <= idx_next;
        if (idx_next == row_q.row_len) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

endmodule

// File: source/spmm.sv
module spmm (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  // sparse rows from the input buffer
  input  logic                                          head_valid_i,
  input  spmm_pkg::hrow_t                               head_row_i,
  output logic                                          pop_o,
  // weight columns
  input  spmm_pkg::wrow_t [spmm_pkg::W_NUM_OF_COLS-1:0] w_cols_i,
  // dense output rows
  output logic                                          out_valid_o,
  output spmm_pkg::out_row_t                            out_row_o,
  input  logic                                          out_credit_i
);
  import spmm_pkg::*;

  spmm_state_t               state_q;
  spmm_state_t               state_d;
  credit_t                   credit_q;
  logic                      last_q;
  logic                      out_valid_q;
  out_row_t                  out_row_q;
  logic [W_NUM_OF_COLS-1:0]  lane_done;
  data_t [W_NUM_OF_COLS-1:0] lane_result;
  logic                      all_done;
  logic                      has_credit;
  logic                      emit;

  assign has_credit  = (credit_q != '0);
  assign all_done    = &lane_done;

  // accept a row and start the lanes in one cycle
  assign pop_o       = (state_q == IDLE) && head_valid_i;

  assign out_valid_o = out_valid_q;
  assign out_row_o   = out_row_q;

  always_comb begin
    state_d = state_q;
    emit    = 1'b0;
    case (state_q)
      IDLE: begin
        if (head_valid_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (all_done) begin
          if (has_credit) begin
            emit    = 1'b1;
            state_d = IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        // lanes keep their sums until the next start
        if (has_credit) begin
          emit    = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      out_valid_q <= emit;
    end
  end

  // output credits, taken while out_valid_o is high
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= credit_t'(OUT_CREDITS);
    end else begin
      case ({out_credit_i, out_valid_q})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // last flag and result payload
  always_ff @(posedge clk) begin
    if (pop_o) begin
      last_q <= head_row_i.last;
    end
    if (emit) begin
      out_row_q.data <= lane_result;
      out_row_q.last <= last_q;
    end
  end

  // one lane per W column
  for (genvar i = 0; i < W_NUM_OF_COLS; i++) begin : g_lane
    spv u_spv (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .start_i  (pop_o),
      .row_i    (head_row_i),
      .wcol_i   (w_cols_i[i]),
      .done_o   (lane_done[i]),
      .result_o (lane_result[i])
    );
  end

endmodule

// File: source/spmm_top.sv
module spmm_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // weight load
  input  logic                  wt_we_i,
  input  spmm_pkg::col_idx_t    wt_row_i,
  input  spmm_pkg::wrow_t       wt_data_i,
  // sparse rows in, credit based
  input  logic                  hrow_valid_i,
  input  spmm_pkg::hrow_t       hrow_i,
  output logic                  hrow_credit_o,
  // dense rows out, credit based
  output logic                  out_valid_o,
  output spmm_pkg::out_row_t    out_row_o,
  input  logic                  out_credit_i
);
  import spmm_pkg::*;

  logic                     head_valid;
  hrow_t                    head_row;
  logic                     pop;
  wrow_t [W_NUM_OF_COLS-1:0] w_cols;

  row_fifo u_row_fifo (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_i       (hrow_valid_i),
    .push_row_i   (hrow_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_row_o   (head_row),
    .credit_o     (hrow_credit_o)
  );

  weight_store u_weight_store (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (wt_we_i),
    .row_i   (wt_row_i),
    .data_i  (wt_data_i),
    .cols_o  (w_cols)
  );

  spmm u_spmm (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_row_i   (head_row),
    .pop_o        (pop),
    .w_cols_i     (w_cols),
    .out_valid_o  (out_valid_o),
    .out_row_o    (out_row_o),
    .out_credit_i (out_credit_i)
  );

endmodule

// File: tb/spmm_asserts.sv
module spmm_asserts (
  input logic              clk,
  input logic              rst_n_i,
  input spmm_pkg::credit_t credit_i,
  input logic              out_valid_i,
  input logic              pop_i
);
  import spmm_pkg::*;

  // read by the testbench
  int unsigned fail_count = 0;

  // counter never rises above its reset value
  credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
    credit_i <= credit_t'(OUT_CREDITS))
  else begin
    $error("output credit count %0d above %0d", credit_i, OUT_CREDITS);
    fail_count++;
  end

  valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i |-> (credit_i != '0))
  else begin
    $error("out_valid_o high with no output credit");
    fail_count++;
  end

  // a popped row keeps the engine busy for at least one cycle
  one_pop_per_row: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |=> !pop_i)
  else begin
    $error("engine popped rows in two consecutive cycles");
    fail_count++;
  end

endmodule

// File: tb/tb_spmm.sv
module tb_spmm;
  import spmm_pkg::*;

  localparam int NUM_ROWS       = 8;
  localparam int HOLD_DELAY     = 40;
  localparam int RAND_DELAY_MAX = 8;
  // held credits are the longest delay
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (DOT_PRODUCT_SIZE + 3 + HOLD_DELAY) + 100;

  logic     clk;
  logic     rst_n_i;
  logic     wt_we_i;
  col_idx_t wt_row_i;
  wrow_t    wt_data_i;
  logic     hrow_valid_i;
  hrow_t    hrow_i;
  logic     hrow_credit_o;
  logic     out_valid_o;
  out_row_t out_row_o;
  logic     out_credit_i;

  integer   seed;
  int       cycle;
  int       sent;
  int       send_credits;
  int       received;
  int       returned;
  int       last_due;
  int       due_q[$];
  data_t    w [DOT_PRODUCT_SIZE][W_NUM_OF_COLS];
  hrow_t    table_row [NUM_ROWS];
  out_row_t table_exp [NUM_ROWS];

  // column index, value and length per table entry
  // tails past the length are junk
  int unsigned tbl_cols [NUM_ROWS][DOT_PRODUCT_SIZE] = '{
    '{0, 1, 2, 3, 4}, '{7, 6, 5, 7, 6}, '{3, 3, 0, 4, 1}, '{4, 1, 7, 5, 6},
    '{2, 2, 2, 2, 2}, '{0, 7, 7, 7, 7}, '{4, 0, 2, 6, 5}, '{1, 3, 0, 2, 4}};
  int unsigned tbl_vals [NUM_ROWS][DOT_PRODUCT_SIZE] = '{
    '{200, 150, 255, 99, 17}, '{170, 85, 240, 15, 204}, '{5, 7, 9, 11, 250},
    '{128, 64, 255, 255, 255}, '{1, 2, 3, 4, 5}, '{255, 1, 2, 3, 4},
    '{33, 66, 99, 77, 88}, '{250, 251, 252, 253, 254}};
  int unsigned tbl_len [NUM_ROWS] = '{5, 0, 4, 2, 5, 1, 3, 5};

  spmm_top dut0 (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .wt_we_i       (wt_we_i),
    .wt_row_i      (wt_row_i),
    .wt_data_i     (wt_data_i),
    .hrow_valid_i  (hrow_valid_i),
    .hrow_i        (hrow_i),
    .hrow_credit_o (hrow_credit_o),
    .out_valid_o   (out_valid_o),
    .out_row_o     (out_row_o),
    .out_credit_i  (out_credit_i)
  );

  bind spmm spmm_asserts u_asserts (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .credit_i     (credit_q),
    .out_valid_i  (out_valid_o),
    .pop_i        (pop_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_last(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // sum over valid entries of value times W[col][c] kept modulo 256
  function automatic out_row_t expected_row(input hrow_t row);
    out_row_t r;
    int       sum;
    for (int c = 0; c < W_NUM_OF_COLS; c++) begin
      sum = 0;
      for (int e = 0; e < int'(row.row_len); e++) begin
        sum = sum + int'(row.value[e]) * int'(w[row.col_idx[e]][c]);
      end
      r.data[c] = data_t'(sum % 256);
    end
    r.last = row.last;
    return r;
  endfunction

  task automatic build_table();
    for (int n = 0; n < NUM_ROWS; n++) begin
      for (int e = 0; e < DOT_PRODUCT_SIZE; e++) begin
        table_row[n].col_idx[e] = col_idx_t'(tbl_cols[n][e]);
        table_row[n].value[e]   = data_t'(tbl_vals[n][e]);
      end
      table_row[n].row_len = row_len_t'(tbl_len[n]);
      table_row[n].last    = (n == NUM_ROWS - 1);
      table_exp[n]         = expected_row(table_row[n]);
    end
  endtask

  task automatic load_weights();
    for (int k = 0; k < DOT_PRODUCT_SIZE; k++) begin
      @(negedge clk);
      wt_we_i  = 1'b1;
      wt_row_i = col_idx_t'(k);
      for (int c = 0; c < W_NUM_OF_COLS; c++) begin
        wt_data_i[c] = w[k][c];
      end
    end
    @(negedge clk);
    wt_we_i = 1'b0;
  endtask

  // sender sends one row per cycle while it holds a credit
  task automatic send_rows();
    while (sent < NUM_ROWS) begin
      @(negedge clk);
      if (hrow_credit_o === 1'b1) begin
        send_credits++;
      end
      if (send_credits > FIFO_DEPTH) begin
        stop_on_error("input buffer returned more credits than it has slots");
      end
      if (send_credits > 0) begin
        hrow_valid_i = 1'b1;
        hrow_i       = table_row[sent];
        sent++;
        send_credits--;
      end else begin
        hrow_valid_i = 1'b0;
      end
    end
    @(negedge clk);
    hrow_valid_i = 1'b0;
  endtask

  task automatic schedule_credit(input int delay);
    int due;
    due = cycle + delay;
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    due_q.push_back(due);
  endtask

  task automatic collect_rows();
    int delay;
    for (int n = 0; n < NUM_ROWS; n++) begin
      do begin
        @(negedge clk);
      end while (out_valid_o !== 1'b1);
      received++;
      for (int c = 0; c < W_NUM_OF_COLS; c++) begin
        check_data($sformatf("out_row_o.data[%0d] row %0d", c, n),
                   out_row_o.data[c], table_exp[n].data[c]);
      end
      check_last($sformatf("out_row_o.last row %0d", n), out_row_o.last, table_exp[n].last);
      if (received - returned > OUT_CREDITS) begin
        stop_on_error("more rows were emitted than the output credits allow");
      end
      // first rows keep their credits for a long time
      if (n < OUT_CREDITS) begin
        delay = HOLD_DELAY;
      end else begin
        delay = 1 + ($unsigned($random(seed)) % RAND_DELAY_MAX);
      end
      schedule_credit(delay);
    end
  endtask

  // engine full, buffer full, sender out of credits
  task automatic check_stall();
    if (received != OUT_CREDITS) begin
      stop_on_error("rows were emitted while output credits were withheld");
    end
    if (sent != OUT_CREDITS + 1 + FIFO_DEPTH || send_credits != 0) begin
      stop_on_error("sender was not throttled while output credits were withheld");
    end
  endtask

  // consumer credit returns
  always @(negedge clk) begin
    if (due_q.size() != 0 && due_q[0] <= cycle) begin
      if (returned == 0) begin
        check_stall();
      end
      out_credit_i = 1'b1;
      void'(due_q.pop_front());
      returned++;
    end else begin
      out_credit_i = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (dut0.u_spmm.u_asserts.fail_count != 0) begin
      stop_on_error("concurrent assertions on the engine failed");
    end
    if (cycle > TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout, only %0d of %0d output rows arrived",
                              received, NUM_ROWS));
    end
  end

  initial begin
    seed         = 75931;
    cycle        = 0;
    sent         = 0;
    send_credits = FIFO_DEPTH;
    received     = 0;
    returned     = 0;
    last_due     = 0;
    rst_n_i      = 1'b0;
    wt_we_i      = 1'b0;
    wt_row_i     = '0;
    wt_data_i    = '0;
    hrow_valid_i = 1'b0;
    hrow_i       = '0;
    out_credit_i = 1'b0;
    for (int k = 0; k < DOT_PRODUCT_SIZE; k++) begin
      for (int c = 0; c < W_NUM_OF_COLS; c++) begin
        w[k][c] = data_t'($random(seed));
      end
    end
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    if (out_valid_o !== 1'b0 || hrow_credit_o !== 1'b0) begin
      stop_on_error("out_valid_o or hrow_credit_o is not low after reset");
    end
    load_weights();
    fork
      send_rows();
      collect_rows();
    join
    @(negedge clk);
    if (dut0.u_spmm.u_asserts.fail_count != 0) begin
      stop_on_error("concurrent assertions on the engine failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: sim.f
source/spmm_pkg.sv
source/row_fifo.sv
source/weight_store.sv
source/spv.sv
source/spmm.sv
source/spmm_top.sv
tb/spmm_asserts.sv
tb/tb_spmm.sv

// File: Bender.yml
package:
  name: spmm

sources:
  - files:
      - source/spmm_pkg.sv
      - source/row_fifo.sv
      - source/weight_store.sv
      - source/spv.sv
      - source/spmm.sv
      - source/spmm_top.sv
  - target: test
    files:
      - tb/spmm_asserts.sv
      - tb/tb_spmm.sv
